// ==== include/tb_encode.svh ====
// instruction encoders for the testbench
// R, I, U, B and J formats of RV32I
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

// register-register ALU op
function automatic rv_core_pkg::word_t enc_r(input logic [6:0] funct7,
                                             input rv_core_pkg::reg_addr_t rs2,
                                             input rv_core_pkg::reg_addr_t rs1,
                                             input logic [2:0] funct3,
                                             input rv_core_pkg::reg_addr_t rd);
    return {funct7, rs2, rs1, funct3, rd, rv_core_pkg::OPC_OP};
endfunction

// OP-IMM and JALR, opcode given by the caller
function automatic rv_core_pkg::word_t enc_i(input logic [6:0] opcode,
                                             input logic [11:0] imm,
                                             input rv_core_pkg::reg_addr_t rs1,
                                             input logic [2:0] funct3,
                                             input rv_core_pkg::reg_addr_t rd);
    return {imm, rs1, funct3, rd, opcode};
endfunction

// LUI or AUIPC
function automatic rv_core_pkg::word_t enc_u(input logic [6:0] opcode,
                                             input logic [19:0] imm,
                                             input rv_core_pkg::reg_addr_t rd);
    return {imm, rd, opcode};
endfunction

// byte offset, bit 0 dropped
function automatic rv_core_pkg::word_t enc_b(input logic [12:0] imm,
                                             input rv_core_pkg::reg_addr_t rs2,
                                             input rv_core_pkg::reg_addr_t rs1,
                                             input logic [2:0] funct3);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11],
            rv_core_pkg::OPC_BRANCH};
endfunction

function automatic rv_core_pkg::word_t enc_j(input logic [20:0] imm,
                                             input rv_core_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::OPC_JAL};
endfunction

`endif

// ==== dv/tb_core_top.sv ====
// clock, reset, instruction memory model, reference register model
// and retire checks for the core top level
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;
    import rv_core_pkg::*;

    `include "tb_encode.svh"

    logic    clk;
    logic    reset;
    logic    imem_req;
    word_t   imem_addr;
    word_t   imem_rdata;
    logic    retire_valid;
    retire_t retire;

    word_t imem [word_t];  // sparse program by byte address
    word_t model_regs [32];
    word_t exp_pc;
    word_t end_pc;
    word_t lcg_state;
    logic  req_seen;
    word_t addr_seen;
    int    prog_len;
    int    retired;
    int    mismatches;
    int    timeouts;
    int    cycles;

    core_top u_core_top (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #10 clk = ~clk;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic word_t read_imem(input word_t addr);
        return imem.exists(addr) ? imem[addr] : 32'h0;  // empty slots decode as no-ops
    endfunction

    task automatic emit(input word_t w);
        imem[RESET_PC + 32'(4 * prog_len)] = w;
        prog_len++;
    endtask

    task automatic mismatch(input string name, input word_t got, input word_t exp);
        mismatches++;
        $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    // request sampled in the fetch cycle and answered early in the next one
    always @(negedge clk) begin
        req_seen  <= imem_req;
        addr_seen <= imem_addr;
    end

    always @(posedge clk) begin
        #1;
        if (req_seen === 1'b1) begin
            imem_rdata = read_imem(addr_seen);
        end
    end

    function automatic word_t alu_expect(input logic [2:0] f3, input logic alt,
                                         input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_expect(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // RV32I result of one instruction against the model registers
    task automatic predict(input word_t pc, input word_t w, output logic we,
                           output word_t wdata, output word_t npc);
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_b;
        word_t imm_j;
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        we    = 1'b1;
        wdata = '0;
        npc   = pc + 32'd4;
        case (w[6:0])
            OPC_OP:     wdata = alu_expect(w[14:12], w[30], a, b);
            OPC_OP_IMM: wdata = alu_expect(w[14:12], w[30] && (w[14:12] == 3'd5), a, imm_i);
            OPC_LUI:    wdata = {w[31:12], 12'h000};
            OPC_AUIPC:  wdata = pc + {w[31:12], 12'h000};
            OPC_JAL: begin
                wdata = pc + 32'd4;
                npc   = pc + imm_j;
            end
            OPC_JALR: begin
                wdata = pc + 32'd4;
                npc   = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                we = 1'b0;
                if (branch_expect(w[14:12], a, b)) begin
                    npc = pc + imm_b;
                end
            end
            default: we = 1'b0;  // loads, system and anything unknown
        endcase
    endtask

    task automatic check_retire();
        word_t w;
        logic  exp_we;
        word_t exp_wdata;
        word_t npc;
        w = read_imem(exp_pc);
        predict(exp_pc, w, exp_we, exp_wdata, npc);
        a_pc: assert (retire.pc === exp_pc) else mismatch("retire.pc", retire.pc, exp_pc);
        a_we: assert (retire.we === exp_we) else mismatch("retire.we", retire.we, exp_we);
        a_next_addr: assert (imem_addr === npc) else mismatch("imem_addr", imem_addr, npc);
        if (exp_we) begin
            a_rd: assert (retire.rd === w[11:7]) else mismatch("retire.rd", retire.rd, w[11:7]);
            a_wdata: assert (retire.wdata === exp_wdata)
                else mismatch("retire.wdata", retire.wdata, exp_wdata);
            if (w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = exp_wdata;
            end
        end
        exp_pc = npc;
        retired++;
    endtask

    always @(negedge clk) begin
        if (reset === 1'b0 && retire_valid === 1'b1) begin
            check_retire();
        end
    end

    // fetch and execute strictly alternate and retire lands in the fetch cycle
    a_req_low: assert property (@(posedge clk) disable iff (reset)
        (!reset && imem_req) |=> !imem_req) else mismatch("imem_req", 32'd1, 32'd0);
    a_req_high: assert property (@(posedge clk) disable iff (reset)
        (!reset && !imem_req) |=> imem_req) else mismatch("imem_req", 32'd0, 32'd1);
    a_retire_after_exec: assert property (@(posedge clk) disable iff (reset)
        (!reset && !imem_req) |=> retire_valid) else mismatch("retire_valid", 32'd0, 32'd1);
    a_retire_in_fetch: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> imem_req) else mismatch("imem_req", 32'd0, 32'd1);

    task automatic build_program();
        word_t      r;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        word_t      filler;
        logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        reg_addr_t  br_rs1 [3] = '{5'd10, 5'd11, 5'd11};
        reg_addr_t  br_rs2 [3] = '{5'd11, 5'd12, 5'd10};
        filler = enc_i(OPC_OP_IMM, 12'd1, 5'd13, 3'd0, 5'd13);  // counts skipped slots
        for (int i = 1; i < 16; i++) begin
            r = lcg_next();
            emit(enc_u(OPC_LUI, r[31:12], reg_addr_t'(i)));
            emit(enc_i(OPC_OP_IMM, r[11:0], reg_addr_t'(i), 3'd0, reg_addr_t'(i)));
        end
        for (int i = 0; i < 60; i++) begin
            r  = lcg_next();
            f3 = r[18:16];
            f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0000000;
            if (r[31]) begin
                emit(enc_r(f7, {1'b0, r[15:12]}, {1'b0, r[23:20]}, f3, {1'b0, r[27:24]}));
            end else begin
                imm = (f3 == 3'd1 || f3 == 3'd5) ? {(f3 == 3'd5) ? f7 : 7'd0, r[4:0]} : r[11:0];
                emit(enc_i(OPC_OP_IMM, imm, {1'b0, r[23:20]}, f3, {1'b0, r[27:24]}));
            end
        end
        emit(enc_i(OPC_OP_IMM, 12'h123, 5'd1, 3'd0, 5'd0));  // dropped write to x0
        emit(enc_r(7'd0, 5'd2, 5'd0, 3'd0, 5'd7));
        emit(enc_r(7'd0, 5'd0, 5'd0, 3'd6, 5'd8));
        emit(enc_i(OPC_OP_IMM, 12'hffb, 5'd0, 3'd0, 5'd10));  // x10 = -5
        emit(enc_i(OPC_OP_IMM, 12'd3, 5'd0, 3'd0, 5'd11));
        emit(enc_i(OPC_OP_IMM, 12'd3, 5'd0, 3'd0, 5'd12));
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                emit(enc_b(13'd8, br_rs2[p], br_rs1[p], br_f3[k]));
                emit(filler);
            end
        end
        emit(enc_j(21'd8, 5'd14));
        emit(filler);
        emit(enc_u(OPC_AUIPC, 20'h0, 5'd5));
        emit(enc_i(OPC_JALR, 12'd13, 5'd5, 3'd0, 5'd6));  // odd target with bit 0 cleared
        emit(filler);
        emit(enc_u(OPC_AUIPC, 20'h0, 5'd5));
        emit(enc_i(OPC_JALR, 12'd12, 5'd5, 3'd0, 5'd5));  // rd equals rs1
        emit(filler);
        r = lcg_next();
        emit(enc_u(OPC_LUI, r[31:12], 5'd20));
        emit(enc_u(OPC_AUIPC, r[19:0], 5'd21));
        emit(enc_i(7'b0000011, 12'h0, 5'd1, 3'd2, 5'd22));  // lw
        emit(32'h0000_0073);  // ecall
        emit(enc_r(7'd0, 5'd0, 5'd22, 3'd0, 5'd23));
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        imem_rdata = '0;
        req_seen   = 1'b0;
        addr_seen  = '0;
        lcg_state  = 32'd62535;
        prog_len   = 0;
        retired    = 0;
        mismatches = 0;
        timeouts   = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        exp_pc = RESET_PC;
        end_pc = RESET_PC + 32'(4 * prog_len);

        @(posedge clk);
        @(negedge clk);
        a_rv_reset: assert (retire_valid === 1'b0) else mismatch("retire_valid", retire_valid, 0);
        a_req_reset: assert (imem_req === 1'b0) else mismatch("imem_req", imem_req, 0);
        @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        a_rv_first: assert (retire_valid === 1'b0) else mismatch("retire_valid", retire_valid, 0);
        a_req_first: assert (imem_req === 1'b1) else mismatch("imem_req", imem_req, 1);
        a_addr_first: assert (imem_addr === RESET_PC) else mismatch("imem_addr", imem_addr, RESET_PC);

        cycles = 0;
        while (exp_pc != end_pc && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_pc != end_pc) begin
            timeouts++;
            $display("timeout: core did not retire up to the end of the program");
        end
        @(negedge clk);

        $display("retired %0d, mismatches %0d, timeouts %0d", retired, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
source/rv_core_pkg.sv
source/fetch_unit.sv
source/inst_decoder.sv
source/alu.sv
source/reg_file.sv
source/execute_unit.sv
source/core_top.sv
dv/tb_core_top.sv

// ==== source/alu.sv ====
// integer add/sub, shifts, compares and bitwise logic
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    input  rv_core_pkg::alu_op_t op,
    output rv_core_pkg::word_t   result
);
    import rv_core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];  // upper bits ignored
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        unique case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN - 1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN - 1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);  // keeps sign
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/core_top.sv ====
// core top level, fetch unit, register file and execute unit
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 imem_req,
    output rv_core_pkg::word_t   imem_addr,
    input  rv_core_pkg::word_t   imem_rdata,
    output logic                 retire_valid,
    output rv_core_pkg::retire_t retire
);
    import rv_core_pkg::*;

    redirect_t redirect;
    logic      exec_valid;
    word_t     pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    fetch_unit u_fetch_unit (
        .clk        (clk),
        .reset      (reset),
        .redirect   (redirect),
        .exec_valid (exec_valid),
        .pc         (pc),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // instruction word comes straight from memory in the execute cycle
    execute_unit u_execute_unit (
        .clk          (clk),
        .reset        (reset),
        .exec_valid   (exec_valid),
        .pc           (pc),
        .inst         (imem_rdata),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .redirect     (redirect),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
// operand select, branch decision, write-back select and the retire register
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   exec_valid,
    input  rv_core_pkg::word_t     pc,
    input  rv_core_pkg::word_t     inst,
    output rv_core_pkg::reg_addr_t rs1_addr,
    output rv_core_pkg::reg_addr_t rs2_addr,
    input  rv_core_pkg::word_t     rs1_data,
    input  rv_core_pkg::word_t     rs2_data,
    output logic                   rf_we,
    output rv_core_pkg::reg_addr_t rf_waddr,
    output rv_core_pkg::word_t     rf_wdata,
    output rv_core_pkg::redirect_t redirect,
    output logic                   retire_valid,
    output rv_core_pkg::retire_t   retire
);
    import rv_core_pkg::*;

    decoded_inst_t dec;
    word_t         alu_a;
    word_t         alu_b;
    word_t         alu_result;
    word_t         link_pc;
    logic          is_jal;
    logic          is_jalr;
    logic          branch_taken;

    inst_decoder u_inst_decoder (
        .inst (inst),
        .dec  (dec)
    );

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;
    assign is_jal   = (dec.inst_type == TYPE_J);
    assign is_jalr  = (dec.opcode == OPC_JALR);
    assign link_pc  = pc + 32'd4;

    // the ALU also forms every jump and branch target
    always_comb begin
        unique case (dec.inst_type)
            TYPE_U:         alu_a = (dec.opcode == OPC_LUI) ? '0 : pc;
            TYPE_J, TYPE_B: alu_a = pc;
            default:        alu_a = rs1_data;  // R, I, JALR
        endcase
    end

    assign alu_b = (dec.inst_type == TYPE_R) ? rs2_data : dec.imm;

    always_comb begin
        branch_taken = 1'b0;
        if (dec.inst_type == TYPE_B) begin
            unique case (dec.funct3)
                3'b000:  branch_taken = (rs1_data == rs2_data);                    // beq
                3'b001:  branch_taken = (rs1_data != rs2_data);                    // bne
                3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));   // blt
                3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));  // bge
                3'b110:  branch_taken = (rs1_data < rs2_data);                     // bltu
                3'b111:  branch_taken = (rs1_data >= rs2_data);                    // bgeu
                default: branch_taken = 1'b0;
            endcase
        end
    end

    assign redirect.jump_en = exec_valid && (is_jal || is_jalr || branch_taken);
    assign redirect.target  = is_jalr ? {alu_result[XLEN-1:1], 1'b0} : alu_result;

    // branches and no-ops leave the register file alone
    assign rf_we    = exec_valid && (dec.inst_type != TYPE_B) && (dec.inst_type != TYPE_NONE);
    assign rf_waddr = dec.rd;
    assign rf_wdata = (is_jal || is_jalr) ? link_pc : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= exec_valid;  // one pulse per instruction
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid) begin
            retire.pc    <= pc;
            retire.rd    <= rf_waddr;
            retire.we    <= rf_we;
            retire.wdata <= rf_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
// program counter and the two-state fetch/execute sequencer
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::redirect_t redirect,
    output logic                   exec_valid,
    output rv_core_pkg::word_t     pc,
    output logic                   imem_req,
    output rv_core_pkg::word_t     imem_addr
);
    import rv_core_pkg::*;

    typedef enum logic {
        FETCH,
        EXEC
    } state_t;

    state_t state;
    state_t state_next;
    word_t  pc_next;

    // strictly alternating with one instruction in flight
    always_comb begin
        unique case (state)
            FETCH:   state_next = EXEC;
            EXEC:    state_next = FETCH;
            default: state_next = FETCH;
        endcase
    end

    // jump or taken branch wins over the sequential pc
    assign pc_next = redirect.jump_en ? redirect.target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (state == EXEC) begin
            pc <= pc_next;  // advance once per instruction
        end
    end

    assign imem_req   = (state == FETCH) && !reset;  // no request while in reset
    assign imem_addr  = pc;
    assign exec_valid = (state == EXEC);  // word from memory is valid here

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
// instruction field split, format classification, immediate build
// and ALU operation select
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  rv_core_pkg::word_t         inst,
    output rv_core_pkg::decoded_inst_t dec
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    inst_type_t inst_type;
    alu_op_t    alu_op;
    word_t      imm;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        unique case (opcode)
            OPC_OP:               inst_type = TYPE_R;
            OPC_OP_IMM, OPC_JALR: inst_type = TYPE_I;
            OPC_LUI, OPC_AUIPC:   inst_type = TYPE_U;
            OPC_JAL:              inst_type = TYPE_J;
            OPC_BRANCH:           inst_type = TYPE_B;
            default:              inst_type = TYPE_NONE;  // loads, stores, system
        endcase
    end

    always_comb begin
        unique case (inst_type)
            TYPE_I: imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_U: imm = {inst[31:12], 12'h000};
            TYPE_B: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            TYPE_J: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;  // R form and no-ops
        endcase
    end

    // only OP and OP-IMM use funct3; everything else adds
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            unique case (funct3)
                3'b000: begin
                    // ADDI has no SUB form, funct7 there is immediate bits
                    if (inst_type == TYPE_R && funct7[5]) begin
                        alu_op = ALU_SUB;
                    end
                end
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;  // both forms
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        dec.inst_type = inst_type;
        dec.opcode    = opcode;
        dec.funct3    = funct3;
        dec.alu_op    = alu_op;
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm;
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// 32 x 32 integer register file, two read ports, x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::reg_addr_t raddr1,
    input  rv_core_pkg::reg_addr_t raddr2,
    output rv_core_pkg::word_t     rdata1,
    output rv_core_pkg::word_t     rdata2,
    input  logic                   we,
    input  rv_core_pkg::reg_addr_t waddr,
    input  rv_core_pkg::word_t     wdata
);
    import rv_core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, same cycle as the address
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== source/rv_core_pkg.sv ====
// shared widths, reset pc, opcode constants
// plus the enums and structs passed between the core blocks
`default_nettype none

package rv_core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;      // data or address word
    typedef logic [4:0]      reg_addr_t;  // register index

    localparam word_t RESET_PC = 32'h8000_0000;

    // base opcodes the core executes, anything else retires as a no-op
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_U,
        TYPE_J,
        TYPE_B,
        TYPE_NONE  // unknown or dropped opcode
    } inst_type_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        inst_type_t inst_type;
        logic [6:0] opcode;
        logic [2:0] funct3;
        alu_op_t    alu_op;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;  // already sign extended
    } decoded_inst_t;

    // next pc override from the execute unit
    typedef struct packed {
        logic  jump_en;
        word_t target;
    } redirect_t;

    // one finished instruction
    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     wdata;
    } retire_t;

endpackage

`default_nettype wire
